//--- verilog/cache_pkg.sv
// cache geometry constants, field types and the buffered request struct
package cache_pkg;

  // --------------------------------------------------
  // geometry: 4 KiB, 2 ways, 64 sets, 32-byte lines
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 64;
  localparam int STRB_W         = WORD_W / 8;
  localparam int LINE_W         = 256;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
  localparam int OFFSET_W       = $clog2(LINE_W / 8);
  localparam int INDEX_W        = 6;
  localparam int NUM_SETS       = 1 << INDEX_W;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int NUM_WAYS       = 2;

  // --------------------------------------------------
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  typedef logic [NUM_WAYS-1:0]   way_mask_t;

  typedef struct packed {
    logic      is_store;  // 1 = store
    index_t    index;
    tag_t      tag;
    word_sel_t word;      // word within the line
    strb_t     strb;
    word_t     wdata;
  } req_t;

endpackage

//--- verilog/array_wr_if.sv
// word write port into the data array, with byte strobes
`timescale 1ns/1ps

interface array_wr_if;
  logic                 en;     // write this cycle
  logic                 way;    // target way
  cache_pkg::index_t    index;
  cache_pkg::word_sel_t word;
  cache_pkg::strb_t     strb;   // byte enables
  cache_pkg::word_t     data;

  modport src (output en, way, index, word, strb, data);
  modport dst (input en, way, index, word, strb, data);
endinterface

//--- verilog/cache_tag_array.sv
// valid, dirty and tag storage with hit detection and victim state lookup
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                                      i_clk,
  input  logic                                      i_rst,
  input  cache_pkg::req_t                           i_req,
  input  cache_pkg::way_mask_t                      i_set_dirty_way,
  input  cache_pkg::index_t                         i_set_dirty_index,
  input  logic                                      i_fill_en,
  input  logic                                      i_fill_way,
  input  logic                                      i_fill_dirty,
  output cache_pkg::way_mask_t                      o_hit,
  output cache_pkg::way_mask_t                      o_valid,
  output cache_pkg::way_mask_t                      o_dirty,
  output cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0] o_tags
);

  logic [cache_pkg::NUM_SETS-1:0] valid_q [cache_pkg::NUM_WAYS];
  logic [cache_pkg::NUM_SETS-1:0] dirty_q [cache_pkg::NUM_WAYS];
  cache_pkg::tag_t                tag_q   [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

  // --------------------------------------------------
  // lookup at the buffered request index
  for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
    assign o_valid[w] = valid_q[w][i_req.index];
    assign o_dirty[w] = dirty_q[w][i_req.index];
    assign o_tags[w]  = tag_q[w][i_req.index];
    assign o_hit[w]   = o_valid[w] && (o_tags[w] == i_req.tag);
  end

  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '{default: '0};
      dirty_q <= '{default: '0};
      tag_q   <= '{default: '0};
    end else begin
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        if (i_set_dirty_way[w]) begin
          dirty_q[w][i_set_dirty_index] <= 1'b1;  // drained store hit
        end
      end
      if (i_fill_en) begin
        valid_q[i_fill_way][i_req.index] <= 1'b1;
        dirty_q[i_fill_way][i_req.index] <= i_fill_dirty;  // set by a store miss
        tag_q[i_fill_way][i_req.index]   <= i_req.tag;
      end
    end
  end

endmodule

//--- verilog/cache_data_array.sv
// line storage for both ways, registered line read and strobed word writes
`timescale 1ns/1ps

module cache_data_array (
  input  logic                                       i_clk,
  input  logic                                       i_rd_en,
  input  cache_pkg::index_t                          i_rd_index,
  array_wr_if.dst                                    wb_wr,
  array_wr_if.dst                                    refill_wr,
  output cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] o_line
);

  // word organised so a strobed write touches one word only
  cache_pkg::word_t mem [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS][cache_pkg::WORDS_PER_LINE];

  always_ff @(posedge i_clk) begin
    for (int b = 0; b < cache_pkg::STRB_W; b++) begin
      if (wb_wr.en && wb_wr.strb[b]) begin
        mem[wb_wr.way][wb_wr.index][wb_wr.word][b*8 +: 8] <= wb_wr.data[b*8 +: 8];
      end
      // refill last, it owns the line during a miss
      if (refill_wr.en && refill_wr.strb[b]) begin
        mem[refill_wr.way][refill_wr.index][refill_wr.word][b*8 +: 8] <=
          refill_wr.data[b*8 +: 8];
      end
    end

    if (i_rd_en) begin
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++) begin
          o_line[w][k*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= mem[w][i_rd_index][k];
        end
      end
    end
  end

endmodule

//--- verilog/cache_write_buffer.sv
// one-entry store buffer, drains hit stores and flags read-after-write conflicts
`timescale 1ns/1ps

module cache_write_buffer (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_load,
  input  cache_pkg::req_t      i_req,
  input  cache_pkg::way_mask_t i_hit,
  input  cache_pkg::index_t    i_new_index,
  input  cache_pkg::word_sel_t i_new_word,
  output logic                 o_conflict,
  output cache_pkg::way_mask_t o_dirty_way,
  output cache_pkg::index_t    o_dirty_index,
  array_wr_if.src              wb_wr
);

  logic                 pending_q;  // store waiting to drain
  cache_pkg::way_mask_t way_q;
  cache_pkg::index_t    index_q;
  cache_pkg::word_sel_t word_q;
  cache_pkg::strb_t     strb_q;
  cache_pkg::word_t     data_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= i_load;  // always drains the next cycle
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      way_q   <= i_hit;
      index_q <= i_req.index;
      word_q  <= i_req.word;
      strb_q  <= i_req.strb;
      data_q  <= i_req.wdata;
    end
  end

  // same word pending now or being loaded this cycle
  assign o_conflict = (pending_q && index_q == i_new_index && word_q == i_new_word) ||
                      (i_load && i_req.index == i_new_index && i_req.word == i_new_word);

  assign o_dirty_way   = pending_q ? way_q : '0;
  assign o_dirty_index = index_q;

  assign wb_wr.en    = pending_q;
  assign wb_wr.way   = way_q[1];
  assign wb_wr.index = index_q;
  assign wb_wr.word  = word_q;
  assign wb_wr.strb  = strb_q;
  assign wb_wr.data  = data_q;

endmodule

//--- verilog/cache_miss_unit.sv
// victim choice, dirty write-back, line refill and store merge
`timescale 1ns/1ps

module cache_miss_unit (
  input  logic                                       i_clk,
  input  logic                                       i_rst,
  input  logic                                       i_start,
  input  cache_pkg::req_t                            i_req,
  input  cache_pkg::way_mask_t                       i_valid,
  input  cache_pkg::way_mask_t                       i_dirty,
  input  cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0]  i_tags,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] i_line,
  output logic                                       o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0]               o_rd_addr,
  input  logic                                       i_rd_rdy,
  input  logic                                       i_ret_valid,
  input  logic                                       i_ret_last,
  input  cache_pkg::word_t                           i_ret_data,
  output logic                                       o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0]               o_wr_addr,
  output cache_pkg::line_t                           o_wr_data,
  input  logic                                       i_wr_rdy,
  output logic                                       o_fill_en,
  output logic                                       o_fill_way,
  output logic                                       o_fill_dirty,
  output logic                                       o_word_ok,
  output logic                                       o_done,
  array_wr_if.src                                    refill_wr
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_PREP,    // set re-read in flight, dirty bit settles
    M_WRITE,
    M_READ,
    M_REFILL
  } mstate_t;

  mstate_t              state_q;
  logic                 toggle_q;
  logic                 way_q;
  cache_pkg::word_sel_t beat_q;
  logic                 victim;
  logic                 beat;
  logic                 match;

  function automatic cache_pkg::word_t merge_word(cache_pkg::word_t old_w,
                                                  cache_pkg::word_t new_w,
                                                  cache_pkg::strb_t strb);
    cache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < cache_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign victim = !i_valid[0] ? 1'b0 : (!i_valid[1] ? 1'b1 : toggle_q);  // invalid way first
  assign beat   = (state_q == M_REFILL) && i_ret_valid;
  assign match  = beat && (beat_q == i_req.word);

  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= M_IDLE;
      toggle_q <= 1'b0;
      way_q    <= 1'b0;
      beat_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: begin
          if (i_start) begin
            state_q  <= M_PREP;
            toggle_q <= ~toggle_q;  // flips on every miss
          end
        end
        M_PREP: begin
          way_q   <= victim;
          state_q <= (i_valid[victim] && i_dirty[victim]) ? M_WRITE : M_READ;
        end
        M_WRITE: state_q <= i_wr_rdy ? M_READ : M_WRITE;
        M_READ: begin
          if (i_rd_rdy) begin
            state_q <= M_REFILL;
            beat_q  <= '0;
          end
        end
        M_REFILL: begin
          if (beat) begin
            beat_q  <= beat_q + 1'b1;
            state_q <= i_ret_last ? M_IDLE : M_REFILL;
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // memory side, whole lines only
  assign o_wr_req  = (state_q == M_WRITE);
  assign o_wr_addr = {i_tags[way_q], i_req.index, {cache_pkg::OFFSET_W{1'b0}}};
  assign o_wr_data = i_line[way_q];  // victim line from the re-read
  assign o_rd_req  = (state_q == M_READ);
  assign o_rd_addr = {i_req.tag, i_req.index, {cache_pkg::OFFSET_W{1'b0}}};

  assign refill_wr.en    = beat;
  assign refill_wr.way   = way_q;
  assign refill_wr.index = i_req.index;
  assign refill_wr.word  = beat_q;
  assign refill_wr.strb  = '1;
  assign refill_wr.data  = (match && i_req.is_store) ?
                           merge_word(i_ret_data, i_req.wdata, i_req.strb) : i_ret_data;

  assign o_word_ok    = match && !i_req.is_store;
  assign o_done       = beat && i_ret_last;
  assign o_fill_en    = o_done;
  assign o_fill_way   = way_q;
  assign o_fill_dirty = i_req.is_store;

endmodule

//--- verilog/cache_ctrl.sv
// main FSM, request buffer, hit word select and CPU strobes
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                                       i_clk,
  input  logic                                       i_rst,
  input  logic                                       i_valid,
  input  logic                                       i_op,
  input  logic [cache_pkg::ADDR_W-1:0]               i_addr,
  input  cache_pkg::strb_t                           i_wstrb,
  input  cache_pkg::word_t                           i_wdata,
  input  cache_pkg::way_mask_t                       i_hit,
  input  logic                                       i_conflict,
  input  logic                                       i_miss_done,
  input  logic                                       i_miss_word_ok,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] i_line,
  input  cache_pkg::word_t                           i_ret_data,
  output cache_pkg::req_t                            o_req,
  output logic                                       o_rd_en,
  output cache_pkg::index_t                          o_rd_index,
  output logic                                       o_store_hit,
  output logic                                       o_miss_start,
  output logic                                       o_addr_ok,
  output logic                                       o_data_ok,
  output cache_pkg::word_t                           o_rdata
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_MISS_WAIT
  } state_t;

  state_t           state_q;
  logic             miss_q;    // first miss cycle
  logic             hit;
  logic             lookup;
  logic             accept;
  cache_pkg::line_t hit_line;

  assign hit       = |i_hit;
  assign lookup    = (state_q == S_LOOKUP);
  assign o_addr_ok = ((state_q == S_IDLE) || (lookup && hit)) && !i_conflict;
  assign accept    = i_valid && o_addr_ok;

  // --------------------------------------------------
  // request buffer
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_req.is_store <= i_op;
      o_req.index    <= i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
      o_req.tag      <= i_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
      o_req.word     <= i_addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_SEL_W];
      o_req.strb     <= i_wstrb;
      o_req.wdata    <= i_wdata;
    end
  end

  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= S_IDLE;
      miss_q  <= 1'b0;
    end else begin
      miss_q <= o_miss_start;
      case (state_q)
        S_IDLE:      state_q <= accept ? S_LOOKUP : S_IDLE;
        S_LOOKUP:    state_q <= !hit ? S_MISS_WAIT : (accept ? S_LOOKUP : S_IDLE);
        S_MISS_WAIT: state_q <= i_miss_done ? S_IDLE : S_MISS_WAIT;
        default:     state_q <= S_IDLE;
      endcase
    end
  end

  // re-read the set once on a miss so the victim includes any drained store
  assign o_rd_en    = accept || miss_q;
  assign o_rd_index = miss_q ? o_req.index
                             : i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

  assign o_store_hit  = lookup && hit && o_req.is_store;
  assign o_miss_start = lookup && !hit;

  assign hit_line  = i_hit[1] ? i_line[1] : i_line[0];
  assign o_rdata   = lookup ? hit_line[o_req.word*cache_pkg::WORD_W +: cache_pkg::WORD_W]
                            : i_ret_data;  // refill beat during a miss
  assign o_data_ok = (lookup && (hit || o_req.is_store)) ||
                     ((state_q == S_MISS_WAIT) && i_miss_word_ok);

endmodule

//--- verilog/cache_top.sv
// cache top level with plain CPU and memory ports, wiring the units together
`timescale 1ns/1ps

module cache_top (
  input  logic                         i_clk,
  input  logic                         i_rst,
  // cpu side
  input  logic                         i_valid,
  input  logic                         i_op,       // 1 = store
  input  logic [cache_pkg::ADDR_W-1:0] i_addr,
  input  logic [cache_pkg::STRB_W-1:0] i_wstrb,
  input  logic [cache_pkg::WORD_W-1:0] i_wdata,
  output logic                         o_addr_ok,
  output logic                         o_data_ok,
  output logic [cache_pkg::WORD_W-1:0] o_rdata,
  // memory read side
  output logic                         o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0] o_rd_addr,
  input  logic                         i_rd_rdy,
  input  logic                         i_ret_valid,
  input  logic                         i_ret_last,
  input  logic [cache_pkg::WORD_W-1:0] i_ret_data,
  // memory write side
  output logic                         o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0] o_wr_addr,
  output logic [cache_pkg::LINE_W-1:0] o_wr_data,
  input  logic                         i_wr_rdy
);

  cache_pkg::req_t                            req;
  cache_pkg::way_mask_t                       hit;
  cache_pkg::way_mask_t                       tag_valid;
  cache_pkg::way_mask_t                       tag_dirty;
  cache_pkg::way_mask_t                       dirty_way;
  cache_pkg::index_t                          dirty_index;
  cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0]  tags;
  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] line;
  cache_pkg::index_t                          rd_index;
  logic                                       rd_en;
  logic                                       store_hit;
  logic                                       conflict;
  logic                                       miss_start;
  logic                                       miss_done;
  logic                                       miss_word_ok;
  logic                                       fill_en;
  logic                                       fill_way;
  logic                                       fill_dirty;

  array_wr_if wb_wr ();
  array_wr_if refill_wr ();

  cache_ctrl u_ctrl (
    .i_clk, .i_rst, .i_valid, .i_op, .i_addr, .i_wstrb, .i_wdata,
    .i_hit          (hit),
    .i_conflict     (conflict),
    .i_miss_done    (miss_done),
    .i_miss_word_ok (miss_word_ok),
    .i_line         (line),
    .i_ret_data,
    .o_req          (req),
    .o_rd_en        (rd_en),
    .o_rd_index     (rd_index),
    .o_store_hit    (store_hit),
    .o_miss_start   (miss_start),
    .o_addr_ok, .o_data_ok, .o_rdata
  );

  cache_tag_array u_tags (
    .i_clk, .i_rst,
    .i_req             (req),
    .i_set_dirty_way   (dirty_way),
    .i_set_dirty_index (dirty_index),
    .i_fill_en         (fill_en),
    .i_fill_way        (fill_way),
    .i_fill_dirty      (fill_dirty),
    .o_hit             (hit),
    .o_valid           (tag_valid),
    .o_dirty           (tag_dirty),
    .o_tags            (tags)
  );

  cache_data_array u_data (
    .i_clk,
    .i_rd_en    (rd_en),
    .i_rd_index (rd_index),
    .wb_wr      (wb_wr.dst),
    .refill_wr  (refill_wr.dst),
    .o_line     (line)
  );

  cache_write_buffer u_wbuf (
    .i_clk, .i_rst,
    .i_load        (store_hit),
    .i_req         (req),
    .i_hit         (hit),
    .i_new_index   (i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]),
    .i_new_word    (i_addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_SEL_W]),
    .o_conflict    (conflict),
    .o_dirty_way   (dirty_way),
    .o_dirty_index (dirty_index),
    .wb_wr         (wb_wr.src)
  );

  cache_miss_unit u_miss (
    .i_clk, .i_rst,
    .i_start      (miss_start),
    .i_req        (req),
    .i_valid      (tag_valid),
    .i_dirty      (tag_dirty),
    .i_tags       (tags),
    .i_line       (line),
    .o_rd_req, .o_rd_addr, .i_rd_rdy, .i_ret_valid, .i_ret_last, .i_ret_data,
    .o_wr_req, .o_wr_addr, .o_wr_data, .i_wr_rdy,
    .o_fill_en    (fill_en),
    .o_fill_way   (fill_way),
    .o_fill_dirty (fill_dirty),
    .o_word_ok    (miss_word_ok),
    .o_done       (miss_done),
    .refill_wr    (refill_wr.src)
  );

endmodule

//--- tb/tb_mem_model.sv
// memory responder with random stalls, backing store, pattern content and line write log
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_rd_req,
  input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
  output logic                         o_rd_rdy,
  output logic                         o_ret_valid,
  output logic                         o_ret_last,
  output logic [cache_pkg::WORD_W-1:0] o_ret_data,
  input  logic                         i_wr_req,
  input  logic [cache_pkg::ADDR_W-1:0] i_wr_addr,
  input  logic [cache_pkg::LINE_W-1:0] i_wr_data,
  output logic                         o_wr_rdy
);

  localparam logic [31:0] SEED = 32'h370149d5;

  logic [31:0]      lfsr;
  cache_pkg::word_t store [logic [31:0]];  // written words by byte address
  logic [31:0]      log_addr [$];
  cache_pkg::line_t log_line [$];
  int               rd_xfers;              // line reads taken
  logic [31:0]      line_addr;
  int               beats_left;
  int               beat_idx;

  // initial content, every address bit takes part
  function automatic cache_pkg::word_t pattern_word(input logic [31:0] addr);
    return {addr ^ 32'h9e37_79b9, {addr[15:0], addr[31:16]} + 32'h0bad_f00d};
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  function automatic cache_pkg::word_t read_word(input logic [31:0] addr);
    if (store.exists(addr)) begin
      return store[addr];
    end
    return pattern_word(addr);
  endfunction

  function automatic int log_writes(input logic [31:0] addr);
    int n;
    n = 0;
    foreach (log_addr[i]) begin
      if (log_addr[i] == addr) begin
        n++;
      end
    end
    return n;
  endfunction

  // word from the latest logged write of the line holding addr
  function automatic cache_pkg::word_t log_word(input logic [31:0] addr);
    cache_pkg::word_t w;
    w = 'x;
    foreach (log_addr[i]) begin
      if (log_addr[i] == {addr[31:5], 5'b0}) begin
        w = log_line[i][addr[4:3]*64 +: 64];
      end
    end
    return w;
  endfunction

  // --------------------------------------------------
  // sample at the falling edge, drive just after the rising edge
  initial begin
    logic rd_go;
    logic wr_go;
    logic beat_go;
    logic b0;
    logic b1;
    lfsr        = SEED;
    o_rd_rdy    = 1'b0;
    o_wr_rdy    = 1'b0;
    o_ret_valid = 1'b0;
    o_ret_last  = 1'b0;
    o_ret_data  = '0;
    rd_xfers    = 0;
    beats_left  = 0;
    beat_idx    = 0;
    line_addr   = '0;
    forever begin
      @(negedge i_clk);
      rd_go   = i_rd_req && o_rd_rdy && !i_rst;
      wr_go   = i_wr_req && o_wr_rdy && !i_rst;
      beat_go = o_ret_valid;
      if (wr_go) begin
        for (int k = 0; k < 4; k++) begin
          store[i_wr_addr + 32'(k * 8)] = i_wr_data[k*64 +: 64];
        end
        log_addr.push_back(i_wr_addr);
        log_line.push_back(i_wr_data);
      end
      if (rd_go) begin
        line_addr  = i_rd_addr;
        beats_left = 4;
        beat_idx   = 0;
        rd_xfers++;
      end
      @(posedge i_clk);
      #1;
      if (beat_go) begin
        beat_idx++;
        beats_left--;
      end
      take_bit(b0);
      take_bit(b1);
      o_ret_valid = (beats_left > 0) && (b0 || b1);  // gaps between beats
      o_ret_last  = o_ret_valid && (beats_left == 1);
      o_ret_data  = o_ret_valid ? read_word(line_addr + 32'(beat_idx * 8)) : '0;
      take_bit(b0);
      o_rd_rdy = (beats_left == 0) && b0;
      take_bit(b1);
      o_wr_rdy = b1;
    end
  end

endmodule

//--- tb/tb_cache_top.sv
// cache testbench: clock, reset, directed and random stimulus, reference model and checks
`timescale 1ns/1ps

module tb_cache_top;

  localparam logic [31:0] SEED        = 32'h370149d5;
  localparam int          ACCEPT_WAIT = 400;  // cycles
  localparam int          DRAIN_WAIT  = 400;
  localparam int          RAND_OPS    = 200;

  logic                                   i_clk;
  logic                                   i_rst;
  logic                                   i_valid;
  logic                                   i_op;
  logic [31:0]                            i_addr;
  logic [7:0]                             i_wstrb;
  cache_pkg::word_t                       i_wdata;
  logic                                   o_addr_ok;
  logic                                   o_data_ok;
  cache_pkg::word_t                       o_rdata;
  logic                                   o_rd_req;
  logic [31:0]                            o_rd_addr;
  logic                                   i_rd_rdy;
  logic                                   i_ret_valid;
  logic                                   i_ret_last;
  cache_pkg::word_t                       i_ret_data;
  logic                                   o_wr_req;
  logic [31:0]                            o_wr_addr;
  cache_pkg::line_t                       o_wr_data;
  logic                                   i_wr_rdy;

  logic [31:0]      lfsr;
  cache_pkg::word_t shadow [logic [31:0]];  // reference word memory
  cache_pkg::word_t exp_data [$];
  logic             exp_store [$];
  logic [31:0]      exp_addr [$];
  int               checks;
  int               errors;
  int               tests;
  int               test_start_errors;

  cache_top uut (.*);

  tb_mem_model mem (
    .i_clk, .i_rst,
    .i_rd_req    (o_rd_req),
    .i_rd_addr   (o_rd_addr),
    .o_rd_rdy    (i_rd_rdy),
    .o_ret_valid (i_ret_valid),
    .o_ret_last  (i_ret_last),
    .o_ret_data  (i_ret_data),
    .i_wr_req    (o_wr_req),
    .i_wr_addr   (o_wr_addr),
    .i_wr_data   (o_wr_data),
    .o_wr_rdy    (i_wr_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // reference model
  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                   input cache_pkg::word_t new_w,
                                                   input logic [7:0] strb);
    cache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic cache_pkg::word_t expected_read(input logic [31:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return mem.pattern_word(addr);  // never written
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  // --------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Checks failed");
    $finish;
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Fail at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_start_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
    end
  endtask

  // called just after a rising edge, returns just after the accepting edge
  task automatic issue(input logic op, input logic [31:0] addr, input logic [7:0] strb,
                       input cache_pkg::word_t data);
    int          wait_cnt;
    logic [31:0] wa;
    wa       = {addr[31:3], 3'b0};
    wait_cnt = 0;
    i_valid  = 1'b1;
    i_op     = op;
    i_addr   = wa;
    i_wstrb  = strb;
    i_wdata  = data;
    @(negedge i_clk);
    while (!o_addr_ok) begin
      if (wait_cnt == ACCEPT_WAIT) begin
        fail_run("Timeout waiting for the cache to accept a request");
      end
      wait_cnt++;
      @(negedge i_clk);
    end
    exp_store.push_back(op);
    exp_addr.push_back(wa);
    if (op) begin
      shadow[wa] = merge_bytes(expected_read(wa), data, strb);
    end
    exp_data.push_back(expected_read(wa));
    @(posedge i_clk);
    #1;
  endtask

  task automatic idle();
    i_valid = 1'b0;
  endtask

  task automatic drain();
    int wait_cnt;
    wait_cnt = 0;
    while (exp_data.size() != 0 || !o_addr_ok) begin
      if (wait_cnt == DRAIN_WAIT) begin
        fail_run("Timeout waiting for outstanding responses");
      end
      wait_cnt++;
      @(posedge i_clk);
      #1;
    end
  endtask

  // --------------------------------------------------
  // response checker
  initial begin
    logic             is_store;
    cache_pkg::word_t want;
    logic [31:0]      addr;
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_data_ok) begin
        assert (exp_data.size() != 0) else begin
          $display("Unexpected o_data_ok with no request outstanding at %0t", $time);
          errors++;
        end
        if (exp_data.size() != 0) begin
          is_store = exp_store.pop_front();
          want     = exp_data.pop_front();
          addr     = exp_addr.pop_front();
          if (!is_store) begin
            checks++;
            assert (o_rdata === want) else begin
              $display("Fail at %0t: read %h returned %h, expected %h",
                       $time, addr, o_rdata, want);
              errors++;
            end
          end
        end
      end
    end
  end

  // --------------------------------------------------
  initial begin
    int          rd_before;
    logic [63:0] r;
    logic [1:0]  t;
    logic [1:0]  s;
    logic [1:0]  w;
    logic        op;
    logic [7:0]  strb;
    logic [31:0] addr;
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_op    = 1'b0;
    i_addr  = '0;
    i_wstrb = '0;
    i_wdata = '0;
    lfsr    = SEED;
    checks  = 0;
    errors  = 0;
    tests   = 0;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    begin_test();
    repeat (4) begin
      @(negedge i_clk);
      expect_true(!o_data_ok && !o_rd_req && !o_wr_req && o_addr_ok, "outputs after reset");
    end
    @(posedge i_clk);
    #1;
    finish_test("reset state");

    begin_test();
    rd_before = mem.rd_xfers;
    issue(1'b0, 32'h0000_2048, '0, '0);
    idle();
    drain();
    expect_true(mem.rd_xfers == rd_before + 1, "one line read for the miss");
    rd_before = mem.rd_xfers;
    for (int k = 0; k < 4; k++) begin
      issue(1'b0, 32'h0000_2040 + 32'(k * 8), '0, '0);  // back to back hits
    end
    idle();
    drain();
    expect_true(mem.rd_xfers == rd_before, "no line read for hits in the same line");
    finish_test("read miss then line hits");

    begin_test();
    issue(1'b1, 32'h0000_2050, 8'h0f, 64'h1122_3344_5566_7788);
    issue(1'b0, 32'h0000_2050, '0, '0);  // stalls on the pending store
    idle();
    drain();
    finish_test("store hit then read of the same word");

    begin_test();
    issue(1'b1, 32'h3000_00a8, 8'hc3, 64'hdead_beef_cafe_f00d);
    issue(1'b0, 32'h3000_00a8, '0, '0);
    issue(1'b0, 32'h3000_00b0, '0, '0);
    idle();
    drain();
    finish_test("store miss merge");

    // --------------------------------------------------
    // three more tags in set 9 push the dirty line out
    begin_test();
    issue(1'b1, 32'h0001_0128, 8'hff, 64'h0123_4567_89ab_cdef);
    issue(1'b0, 32'h0002_0128, '0, '0);
    issue(1'b0, 32'h0003_0128, '0, '0);
    issue(1'b0, 32'h0004_0128, '0, '0);
    idle();
    drain();
    expect_true(mem.log_writes(32'h0001_0120) > 0, "dirty line written back");
    expect_true(mem.log_word(32'h0001_0128) === shadow[32'h0001_0128], "written back word");
    issue(1'b0, 32'h0001_0128, '0, '0);
    idle();
    drain();
    finish_test("dirty eviction");

    begin_test();
    for (int n = 0; n < RAND_OPS; n++) begin
      rand_bits(2, r);
      t = r[1:0];
      rand_bits(2, r);
      s = r[1:0];
      rand_bits(2, r);
      w = r[1:0];
      rand_bits(1, r);
      op = r[0];
      rand_bits(8, r);
      strb = r[7:0];
      addr = 32'h0008_0000 | {19'b0, t, 11'b0} | {25'b0, s, 5'b0} | {27'b0, w, 3'b0};
      rand_bits(64, r);
      issue(op, addr, strb, r);
      rand_bits(2, r);
      if (r[1:0] == 2'b00) begin
        idle();  // occasional gap
        @(posedge i_clk);
        #1;
      end
    end
    idle();
    drain();
    finish_test("random reads and stores");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- cache.f
verilog/cache_pkg.sv
verilog/array_wr_if.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_write_buffer.sv
verilog/cache_miss_unit.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/tb_mem_model.sv
tb/tb_cache_top.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/array_wr_if.sv
      - verilog/cache_tag_array.sv
      - verilog/cache_data_array.sv
      - verilog/cache_write_buffer.sv
      - verilog/cache_miss_unit.sv
      - verilog/cache_ctrl.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/tb_cache_top.sv
